// File: source/x86_flags_pkg.sv
/*
 * x86 flags register layout for the writeback stage.
 * Bit positions, pop masks, reset value and the result word union.
 * Referenced by scoped name from execute, result and the interfaces.
 */
`default_nettype none

package x86_flags_pkg;

	// architectural flag positions in the 32-bit flags image
	localparam int cf_bit = 0;
	localparam int pf_bit = 2;
	localparam int af_bit = 4;
	localparam int zf_bit = 6;
	localparam int sf_bit = 7;
	localparam int df_bit = 10;
	localparam int of_bit = 11;

	// one affected bit per flag, order CF PF AF ZF SF DF OF
	localparam int affected_width = 7;

	// popf takes these bits from the stack image
	localparam logic [31:0] pop_writable_mask = 32'h0025_7FD5;
	// and keeps these from the current flags
	localparam logic [31:0] pop_preserved_mask = 32'h00A1_0000;

	// bit 1 always reads as one
	localparam logic [31:0] flags_reset_value = 32'h0000_0002;

	// flags image with one member per architectural bit
	typedef struct packed {
		logic [19:0] rsvd_hi;
		logic of;
		logic df;
		logic intf;
		logic tf;
		logic sf;
		logic zf;
		logic rsvd5;
		logic af;
		logic rsvd3;
		logic pf;
		logic rsvd1;
		logic cf;
	} flags_image_t;

	// one result word, seen as raw data or as a flags image
	typedef union packed {
		logic [31:0] data;
		flags_image_t flags;
	} wb_word_u;

endpackage

`default_nettype wire

// File: source/wb_uop_pkg.sv
/*
 * Micro-op control word layout for the writeback stage.
 * Holds field positions, jump condition codes and the handshake states.
 * Decode splits the word with these positions.
 */
`default_nettype none

package wb_uop_pkg;

	localparam int uop_ctrl_width = 22;

	// ------------------------------------------------------------
	// single-bit control fields
	// ------------------------------------------------------------
	localparam int ld_gpr1       = 0;
	localparam int ld_gpr2       = 1;
	localparam int ld_gpr3       = 2;
	localparam int ld_seg        = 3;
	localparam int ld_mm         = 4;
	localparam int dcache_write  = 5;
	localparam int ld_flags      = 6;
	localparam int ld_eip        = 7;
	localparam int ld_cs         = 8;
	// string compare is split in two micro-ops
	localparam int cmps_first    = 9;
	localparam int cmps_second   = 10;
	localparam int repne         = 11;
	// far transfers park eip/cs for a later micro-op
	localparam int save_neip     = 12;
	localparam int save_ncs      = 13;
	localparam int use_temp_neip = 14;
	localparam int use_temp_ncs  = 15;
	localparam int push_flags    = 16;
	localparam int pop_flags     = 17;
	localparam int cmovc         = 18;
	localparam int halt          = 19;

	// ------------------------------------------------------------
	// jump condition field, top two bits
	// ------------------------------------------------------------
	localparam int jcc_lsb = 20;
	localparam logic [1:0] jcc_none = 2'd0;
	localparam logic [1:0] jcc_jne  = 2'd1;
	localparam logic [1:0] jcc_jnbe = 2'd2;

	// four-phase req/ack handshake
	typedef enum logic [1:0] {
		hs_idle = 2'd0,
		hs_exec = 2'd1,
		hs_hold = 2'd2
	} hs_state_t;

endpackage

`default_nettype wire

// File: source/wb_if.sv
/*
 * Internal buses of the writeback stage.
 * wb_uop_if carries the captured, decoded micro-op from decode.
 * wb_exec_if carries the combinational execute results to result.
 */
`timescale 1ns/10ps
`default_nettype none

interface wb_uop_if;
	logic go;
	logic valid;
	// decoded control bits
	logic ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write;
	logic ld_flags, ld_eip, ld_cs, cmps_first, cmps_second, repne;
	logic save_neip, save_ncs, use_temp_neip, use_temp_ncs;
	logic push_flags, pop_flags, cmovc, halt;
	logic [wb_uop_pkg::uop_ctrl_width-wb_uop_pkg::jcc_lsb-1:0] jcc;
	logic [x86_flags_pkg::affected_width-1:0] affected;
	// data words
	logic [31:0] result_a, result_c, alu_flags, neip, neip_not_taken;
	logic [15:0] ncs;

	modport source (output go, valid, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm,
		dcache_write, ld_flags, ld_eip, ld_cs, cmps_first, cmps_second, repne,
		save_neip, save_ncs, use_temp_neip, use_temp_ncs, push_flags, pop_flags,
		cmovc, halt, jcc, affected, result_a, result_c, alu_flags, neip,
		neip_not_taken, ncs);
	modport sink (input go, valid, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm,
		dcache_write, ld_flags, ld_eip, ld_cs, cmps_first, cmps_second, repne,
		save_neip, save_ncs, use_temp_neip, use_temp_ncs, push_flags, pop_flags,
		cmovc, halt, jcc, affected, result_a, result_c, alu_flags, neip,
		neip_not_taken, ncs);
endinterface

interface wb_exec_if;
	logic [31:0] data1, final_eip, count, flags;
	logic [15:0] final_cs;
	logic branch_not_taken, cmovc_ld_gpr2, repne_terminate, halt;

	modport source (output data1, final_eip, final_cs, count, flags,
		branch_not_taken, cmovc_ld_gpr2, repne_terminate, halt);
	modport sink (input data1, final_eip, final_cs, count, flags,
		branch_not_taken, cmovc_ld_gpr2, repne_terminate, halt);
endinterface

`default_nettype wire

// File: source/wb_decode.sv
/*
 * Handshake and capture front of the writeback stage.
 * Takes one micro-op per four-phase req/ack exchange, holds it stable
 * and splits its control word onto the wb_uop_if bus.
 * go marks the single exec cycle in which the micro-op retires.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_decode
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	output logic ack,
	input  logic uop_valid,
	input  logic [wb_uop_pkg::uop_ctrl_width-1:0] uop_ctrl,
	input  logic [x86_flags_pkg::affected_width-1:0] flags_affected,
	input  logic [31:0] result_a,
	input  logic [31:0] result_c,
	input  logic [31:0] alu_flags,
	input  logic [31:0] neip,
	input  logic [31:0] neip_not_taken,
	input  logic [15:0] ncs,
	wb_uop_if.source uop
);

	wb_uop_pkg::hs_state_t state_q;

	// captured micro-op
	logic valid_q;
	logic [wb_uop_pkg::uop_ctrl_width-1:0] ctrl_q;
	logic [x86_flags_pkg::affected_width-1:0] affected_q;
	logic [31:0] result_a_q, result_c_q, alu_flags_q, neip_q, neip_nt_q;
	logic [15:0] ncs_q;

	// ------------------------------------------------------------
	// handshake FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= wb_uop_pkg::hs_idle;
			ack <= 1'b0;
		end
		else
		begin
			case (state_q)
				wb_uop_pkg::hs_idle:
				begin
					// ack already low here, so req is a fresh request
					if (req)
						state_q <= wb_uop_pkg::hs_exec;
				end
				wb_uop_pkg::hs_exec:
				begin
					state_q <= wb_uop_pkg::hs_hold;
					ack <= 1'b1;
				end
				wb_uop_pkg::hs_hold:
				begin
					// wait for upstream to drop req
					if (!req)
					begin
						state_q <= wb_uop_pkg::hs_idle;
						ack <= 1'b0;
					end
				end
				default:
				begin
					state_q <= wb_uop_pkg::hs_idle;
					ack <= 1'b0;
				end
			endcase
		end
	end

	// capture on request in idle
	always_ff @(posedge clk)
	begin
		if (state_q == wb_uop_pkg::hs_idle && req)
		begin
			valid_q <= uop_valid;
			ctrl_q <= uop_ctrl;
			affected_q <= flags_affected;
			result_a_q <= result_a;
			result_c_q <= result_c;
			alu_flags_q <= alu_flags;
			neip_q <= neip;
			neip_nt_q <= neip_not_taken;
			ncs_q <= ncs;
		end
	end

	// ------------------------------------------------------------
	// field split
	// ------------------------------------------------------------
	assign uop.go = (state_q == wb_uop_pkg::hs_exec);
	assign uop.valid = valid_q;
	assign uop.ld_gpr1 = ctrl_q[wb_uop_pkg::ld_gpr1];
	assign uop.ld_gpr2 = ctrl_q[wb_uop_pkg::ld_gpr2];
	assign uop.ld_gpr3 = ctrl_q[wb_uop_pkg::ld_gpr3];
	assign uop.ld_seg = ctrl_q[wb_uop_pkg::ld_seg];
	assign uop.ld_mm = ctrl_q[wb_uop_pkg::ld_mm];
	assign uop.dcache_write = ctrl_q[wb_uop_pkg::dcache_write];
	assign uop.ld_flags = ctrl_q[wb_uop_pkg::ld_flags];
	assign uop.ld_eip = ctrl_q[wb_uop_pkg::ld_eip];
	assign uop.ld_cs = ctrl_q[wb_uop_pkg::ld_cs];
	assign uop.cmps_first = ctrl_q[wb_uop_pkg::cmps_first];
	assign uop.cmps_second = ctrl_q[wb_uop_pkg::cmps_second];
	assign uop.repne = ctrl_q[wb_uop_pkg::repne];
	assign uop.save_neip = ctrl_q[wb_uop_pkg::save_neip];
	assign uop.save_ncs = ctrl_q[wb_uop_pkg::save_ncs];
	assign uop.use_temp_neip = ctrl_q[wb_uop_pkg::use_temp_neip];
	assign uop.use_temp_ncs = ctrl_q[wb_uop_pkg::use_temp_ncs];
	assign uop.push_flags = ctrl_q[wb_uop_pkg::push_flags];
	assign uop.pop_flags = ctrl_q[wb_uop_pkg::pop_flags];
	assign uop.cmovc = ctrl_q[wb_uop_pkg::cmovc];
	assign uop.halt = ctrl_q[wb_uop_pkg::halt];
	assign uop.jcc = ctrl_q[wb_uop_pkg::uop_ctrl_width-1:wb_uop_pkg::jcc_lsb];
	// payload straight from the capture register
	assign uop.affected = affected_q;
	assign uop.result_a = result_a_q;
	assign uop.result_c = result_c_q;
	assign uop.alu_flags = alu_flags_q;
	assign uop.neip = neip_q;
	assign uop.neip_not_taken = neip_nt_q;
	assign uop.ncs = ncs_q;

endmodule

`default_nettype wire

// File: source/wb_execute.sv
/*
 * Execute core of the writeback stage.
 * Owns the flags register, the saved CMPS pointer and the temporary
 * NEIP/NCS registers; everything else is combinational off the bus.
 * State updates on go, i.e. at the end of the exec cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_execute
(
	input  logic clk,
	input  logic reset,
	wb_uop_if.sink uop,
	wb_exec_if.source exe
);

	// affected mask order mapped onto flag positions
	localparam int flag_pos [x86_flags_pkg::affected_width] = '{
		x86_flags_pkg::cf_bit,
		x86_flags_pkg::pf_bit,
		x86_flags_pkg::af_bit,
		x86_flags_pkg::zf_bit,
		x86_flags_pkg::sf_bit,
		x86_flags_pkg::df_bit,
		x86_flags_pkg::of_bit
	};

	logic [31:0] flags_q;
	logic [31:0] cmps_ptr_q;
	logic [31:0] temp_neip_q;
	logic [15:0] temp_ncs_q;
	logic flags_load;
	x86_flags_pkg::wb_word_u next_w;

	// ------------------------------------------------------------
	// flags merge
	// ------------------------------------------------------------
	assign flags_load = uop.valid & (uop.ld_flags | uop.pop_flags);

	always_comb
	begin
		next_w.data = flags_q;
		if (flags_load)
		begin
			if (uop.pop_flags)
			begin
				// popf: writable bits from the stack, the rest kept
				next_w.data = (uop.result_a & x86_flags_pkg::pop_writable_mask)
					| (flags_q & x86_flags_pkg::pop_preserved_mask);
			end
			else
			begin
				// per-flag select from the alu image
				for (int i = 0; i < x86_flags_pkg::affected_width; i++)
				begin
					if (uop.affected[i])
						next_w.data[flag_pos[i]] = uop.alu_flags[flag_pos[i]];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// architectural and temporary registers
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags_q <= x86_flags_pkg::flags_reset_value;
			cmps_ptr_q <= '0;
			temp_neip_q <= '0;
			temp_ncs_q <= '0;
		end
		else if (uop.go)
		begin
			// unchanged image when the micro-op does not write flags
			flags_q <= next_w.data;
			// first cmps micro-op parks its pointer for the second
			if (uop.cmps_first)
				cmps_ptr_q <= uop.result_a;
			if (uop.save_neip)
				temp_neip_q <= uop.neip;
			if (uop.save_ncs)
				temp_ncs_q <= uop.ncs;
		end
	end

	// ------------------------------------------------------------
	// operand and eip/cs select
	// ------------------------------------------------------------
	always_comb
	begin
		if (uop.cmps_second)
			exe.data1 = cmps_ptr_q;
		else if (uop.push_flags)
			// pushf stores the flags before this micro-op
			exe.data1 = flags_q;
		else
			exe.data1 = uop.result_a;
	end

	// not-taken path wins over the temp register
	assign exe.final_eip = exe.branch_not_taken ? uop.neip_not_taken
		: (uop.use_temp_neip ? temp_neip_q : uop.neip);
	assign exe.final_cs = uop.use_temp_ncs ? temp_ncs_q : uop.ncs;
	assign exe.count = uop.result_c;
	assign exe.flags = next_w.data;

	// ------------------------------------------------------------
	// conditions, on the flags as updated by this micro-op
	// ------------------------------------------------------------
	always_comb
	begin
		case (uop.jcc)
			wb_uop_pkg::jcc_none: exe.branch_not_taken = 1'b0;
			wb_uop_pkg::jcc_jne:  exe.branch_not_taken = next_w.flags.zf;
			wb_uop_pkg::jcc_jnbe: exe.branch_not_taken = next_w.flags.cf | next_w.flags.zf;
			default:              exe.branch_not_taken = 1'b0;
		endcase
	end

	// cmovc writes only on carry
	assign exe.cmovc_ld_gpr2 = uop.cmovc ? next_w.flags.cf : uop.ld_gpr2;
	// repne cmps stops on match or count exhausted
	assign exe.repne_terminate = uop.valid & uop.cmps_second & uop.repne
		& (next_w.flags.zf | (uop.result_c == 32'd0));
	assign exe.halt = uop.valid & uop.halt;

endmodule

`default_nettype wire

// File: source/wb_result.sv
/*
 * Commit register of the writeback stage.
 * Gates every load enable with the valid bit and latches the
 * execute results on go; commit pulses for that one cycle.
 * Outputs then hold until the next micro-op commits.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_result
(
	input  logic clk,
	input  logic reset,
	wb_uop_if.sink uop,
	wb_exec_if.sink exe,
	output logic commit,
	output logic [31:0] data1,
	output logic [31:0] final_eip,
	output logic [15:0] final_cs,
	output logic [31:0] count,
	output logic [31:0] flags,
	output logic ld_gpr1,
	output logic ld_gpr2,
	output logic ld_gpr3,
	output logic ld_seg,
	output logic ld_mm,
	output logic dcache_write,
	output logic ld_flags,
	output logic ld_eip,
	output logic ld_cs,
	output logic halt,
	output logic repne_terminate
);

	logic repne_step;
	logic eip_enable;

	// the repne cmps pair decides eip reload on termination only
	assign repne_step = uop.cmps_second | uop.repne;
	assign eip_enable = repne_step ? exe.repne_terminate : (uop.valid & uop.ld_eip);

	// ------------------------------------------------------------
	// control outputs
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			commit <= 1'b0;
			ld_gpr1 <= 1'b0;
			ld_gpr2 <= 1'b0;
			ld_gpr3 <= 1'b0;
			ld_seg <= 1'b0;
			ld_mm <= 1'b0;
			dcache_write <= 1'b0;
			ld_flags <= 1'b0;
			ld_eip <= 1'b0;
			ld_cs <= 1'b0;
			halt <= 1'b0;
			repne_terminate <= 1'b0;
			flags <= x86_flags_pkg::flags_reset_value;
		end
		else
		begin
			commit <= uop.go;
			if (uop.go)
			begin
				ld_gpr1 <= uop.valid & uop.ld_gpr1;
				// cmovc already folded in by execute
				ld_gpr2 <= uop.valid & exe.cmovc_ld_gpr2;
				ld_gpr3 <= uop.valid & uop.ld_gpr3;
				ld_seg <= uop.valid & uop.ld_seg;
				ld_mm <= uop.valid & uop.ld_mm;
				dcache_write <= uop.valid & uop.dcache_write;
				// popf also writes flags
				ld_flags <= uop.valid & (uop.ld_flags | uop.pop_flags);
				ld_eip <= eip_enable;
				ld_cs <= uop.valid & uop.ld_cs;
				halt <= exe.halt;
				repne_terminate <= exe.repne_terminate;
				flags <= exe.flags;
			end
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (uop.go)
		begin
			data1 <= exe.data1;
			final_eip <= exe.final_eip;
			final_cs <= exe.final_cs;
			count <= exe.count;
		end
	end

endmodule

`default_nettype wire

// File: source/wb_stage.sv
/*
 * Top level of the writeback stage.
 * Upstream hands over one micro-op per four-phase req/ack exchange;
 * commit outputs are valid from the commit pulse until the next one.
 * Decode, execute and result talk over the two internal buses.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_stage
(
	input  logic clk,
	input  logic reset,
	// upstream handshake and micro-op
	input  logic req,
	output logic ack,
	input  logic uop_valid,
	input  logic [wb_uop_pkg::uop_ctrl_width-1:0] uop_ctrl,
	input  logic [x86_flags_pkg::affected_width-1:0] flags_affected,
	input  logic [31:0] result_a,
	input  logic [31:0] result_c,
	input  logic [31:0] alu_flags,
	input  logic [31:0] neip,
	input  logic [31:0] neip_not_taken,
	input  logic [15:0] ncs,
	// commit outputs
	output logic commit,
	output logic [31:0] data1,
	output logic [31:0] final_eip,
	output logic [15:0] final_cs,
	output logic [31:0] count,
	output logic [31:0] flags,
	output logic ld_gpr1,
	output logic ld_gpr2,
	output logic ld_gpr3,
	output logic ld_seg,
	output logic ld_mm,
	output logic dcache_write,
	output logic ld_flags,
	output logic ld_eip,
	output logic ld_cs,
	output logic halt,
	output logic repne_terminate
);

	wb_uop_if uop_bus ();
	wb_exec_if exe_bus ();

	// ------------------------------------------------------------
	// handshake, capture, field split
	// ------------------------------------------------------------
	wb_decode i_decode (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.uop_valid(uop_valid),
		.uop_ctrl(uop_ctrl),
		.flags_affected(flags_affected),
		.result_a(result_a),
		.result_c(result_c),
		.alu_flags(alu_flags),
		.neip(neip),
		.neip_not_taken(neip_not_taken),
		.ncs(ncs),
		.uop(uop_bus.source)
	);

	// flags, selects, conditions
	wb_execute i_execute (
		.clk(clk),
		.reset(reset),
		.uop(uop_bus.sink),
		.exe(exe_bus.source)
	);

	// gated, registered commit
	wb_result i_result (
		.clk(clk),
		.reset(reset),
		.uop(uop_bus.sink),
		.exe(exe_bus.sink),
		.commit(commit),
		.data1(data1),
		.final_eip(final_eip),
		.final_cs(final_cs),
		.count(count),
		.flags(flags),
		.ld_gpr1(ld_gpr1),
		.ld_gpr2(ld_gpr2),
		.ld_gpr3(ld_gpr3),
		.ld_seg(ld_seg),
		.ld_mm(ld_mm),
		.dcache_write(dcache_write),
		.ld_flags(ld_flags),
		.ld_eip(ld_eip),
		.ld_cs(ld_cs),
		.halt(halt),
		.repne_terminate(repne_terminate)
	);

endmodule

`default_nettype wire

// File: dv/wb_stage_tb.sv
/*
 * Testbench for the writeback stage.
 * Reads micro-op stimulus and expected commit outputs from the vector
 * file, runs one four-phase req/ack exchange per vector with a random
 * idle gap, and checks the committed outputs while ack is high.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_stage_tb;

	localparam int clk_period = 4;
	localparam int words_per_vector = 16;
	localparam int max_vectors = 64;
	localparam int cycles_per_vector = 20;
	localparam int ack_limit = 16;

	// vector columns
	localparam int col_valid = 0;
	localparam int col_ctrl = 1;
	localparam int col_affected = 2;
	localparam int col_result_a = 3;
	localparam int col_result_c = 4;
	localparam int col_alu_flags = 5;
	localparam int col_neip = 6;
	localparam int col_neip_nt = 7;
	localparam int col_ncs = 8;
	localparam int col_hold = 9;
	localparam int col_data1 = 10;
	localparam int col_eip = 11;
	localparam int col_cs = 12;
	localparam int col_count = 13;
	localparam int col_flags = 14;
	localparam int col_enables = 15;

	logic clk;
	logic reset;
	logic req;
	logic ack;
	logic uop_valid;
	logic [wb_uop_pkg::uop_ctrl_width-1:0] uop_ctrl;
	logic [x86_flags_pkg::affected_width-1:0] flags_affected;
	logic [31:0] result_a;
	logic [31:0] result_c;
	logic [31:0] alu_flags;
	logic [31:0] neip;
	logic [31:0] neip_not_taken;
	logic [15:0] ncs;
	logic commit;
	logic [31:0] data1;
	logic [31:0] final_eip;
	logic [15:0] final_cs;
	logic [31:0] count;
	logic [31:0] flags;
	logic ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write;
	logic ld_flags, ld_eip, ld_cs, halt, repne_terminate;

	logic [31:0] vec_mem [0:max_vectors*words_per_vector-1];
	int num_vectors;
	int errors;
	int tests_passed;
	int commit_count;
	int seed;

	wb_stage i_dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.uop_valid(uop_valid),
		.uop_ctrl(uop_ctrl),
		.flags_affected(flags_affected),
		.result_a(result_a),
		.result_c(result_c),
		.alu_flags(alu_flags),
		.neip(neip),
		.neip_not_taken(neip_not_taken),
		.ncs(ncs),
		.commit(commit),
		.data1(data1),
		.final_eip(final_eip),
		.final_cs(final_cs),
		.count(count),
		.flags(flags),
		.ld_gpr1(ld_gpr1),
		.ld_gpr2(ld_gpr2),
		.ld_gpr3(ld_gpr3),
		.ld_seg(ld_seg),
		.ld_mm(ld_mm),
		.dcache_write(dcache_write),
		.ld_flags(ld_flags),
		.ld_eip(ld_eip),
		.ld_cs(ld_cs),
		.halt(halt),
		.repne_terminate(repne_terminate)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// commit seen one edge late, like any flop
	always @(posedge clk)
	begin
		if (commit === 1'b1)
			commit_count <= commit_count + 1;
	end

	// ------------------------------------------------------------
	// checking helpers
	// ------------------------------------------------------------
	task automatic check_word(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// same bit order as the enables column
	function automatic logic [31:0] enable_bits();
		return {21'h0, repne_terminate, halt, ld_cs, ld_eip, ld_flags, dcache_write,
			ld_mm, ld_seg, ld_gpr3, ld_gpr2, ld_gpr1};
	endfunction

	// ------------------------------------------------------------
	// one micro-op per req/ack exchange
	// ------------------------------------------------------------
	task automatic run_vector(input int idx);
		int base;
		int gap;
		int edges;
		int hold;
		int commits_before;
		int errors_before;

		base = idx * words_per_vector;
		hold = int'(vec_mem[base + col_hold]);
		errors_before = errors;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk);

		// micro-op first, req one edge later
		@(posedge clk);
		commits_before = commit_count;
		uop_valid <= vec_mem[base + col_valid][0];
		uop_ctrl <= vec_mem[base + col_ctrl][wb_uop_pkg::uop_ctrl_width-1:0];
		flags_affected <= vec_mem[base + col_affected][x86_flags_pkg::affected_width-1:0];
		result_a <= vec_mem[base + col_result_a];
		result_c <= vec_mem[base + col_result_c];
		alu_flags <= vec_mem[base + col_alu_flags];
		neip <= vec_mem[base + col_neip];
		neip_not_taken <= vec_mem[base + col_neip_nt];
		ncs <= vec_mem[base + col_ncs][15:0];
		@(posedge clk);
		req <= 1'b1;

		// idle -> exec -> hold, ack on the second edge
		@(negedge clk);
		edges = 0;
		while (ack !== 1'b1 && edges < ack_limit)
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		assert (ack === 1'b1)
		else
		begin
			$display("ack did not rise within %0d cycles of req on vector %0d", ack_limit, idx);
			errors++;
		end
		check_word("ack_latency", edges, 32'd2);
		check_bit("commit", commit, 1'b1);
		check_word("data1", data1, vec_mem[base + col_data1]);
		check_word("final_eip", final_eip, vec_mem[base + col_eip]);
		check_word("final_cs", {16'h0, final_cs}, vec_mem[base + col_cs]);
		check_word("count", count, vec_mem[base + col_count]);
		check_word("flags", flags, vec_mem[base + col_flags]);
		check_word("enables", enable_bits(), vec_mem[base + col_enables]);

		// back-pressure, req held high
		repeat (hold)
		begin
			@(posedge clk);
			@(negedge clk);
			check_bit("ack", ack, 1'b1);
			check_bit("commit", commit, 1'b0);
		end

		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		edges = 0;
		while (ack !== 1'b0 && edges < ack_limit)
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		assert (ack === 1'b0)
		else
		begin
			$display("ack did not fall within %0d cycles after req dropped on vector %0d",
				ack_limit, idx);
			errors++;
		end

		// exactly one commit, outputs still held
		check_word("commit_count", commit_count - commits_before, 32'd1);
		check_word("data1", data1, vec_mem[base + col_data1]);
		check_word("final_eip", final_eip, vec_mem[base + col_eip]);

		if (errors == errors_before)
		begin
			tests_passed++;
			$display("test %0d vector %0d: ok", idx + 1, idx);
		end
		else
			$display("test %0d vector %0d: %0d errors", idx + 1, idx, errors - errors_before);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		seed = 70;
		errors = 0;
		tests_passed = 0;
		commit_count = 0;
		num_vectors = 0;
		reset = 1'b1;
		req = 1'b0;
		uop_valid = 1'b0;
		uop_ctrl = '0;
		flags_affected = '0;
		result_a = '0;
		result_c = '0;
		alu_flags = '0;
		neip = '0;
		neip_not_taken = '0;
		ncs = '0;

		// fill marks the end of the file, valid column never exceeds 1
		for (int i = 0; i < max_vectors * words_per_vector; i++)
			vec_mem[i] = 32'hF000_0000 | i;
		$readmemh("dv/wb_vectors.hex", vec_mem);
		while (num_vectors < max_vectors
			&& vec_mem[num_vectors * words_per_vector + col_valid] <= 32'd1)
			num_vectors++;

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// reset state, bit 1 of flags set
		@(negedge clk);
		check_bit("ack", ack, 1'b0);
		check_bit("commit", commit, 1'b0);
		check_word("flags", flags, 32'h0000_0002);
		check_word("enables", enable_bits(), 32'h0);
		if (errors == 0)
		begin
			tests_passed++;
			$display("test 0 reset: ok");
		end
		else
			$display("test 0 reset: %0d errors", errors);

		if (num_vectors == 0)
		begin
			$display("no vectors were read from dv/wb_vectors.hex");
			errors++;
		end
		for (int v = 0; v < num_vectors; v++)
			run_vector(v);

		$display("%0d of %0d tests passed, %0d check errors", tests_passed,
			num_vectors + 1, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog, sized from the vector count
	initial
	begin
		wait (num_vectors > 0);
		#(num_vectors * cycles_per_vector * clk_period);
		$display("timeout after %0d cycles, the handshakes did not complete",
			num_vectors * cycles_per_vector);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
source/x86_flags_pkg.sv
source/wb_uop_pkg.sv
source/wb_if.sv
source/wb_decode.sv
source/wb_execute.sv
source/wb_result.sv
source/wb_stage.sv
dv/wb_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = wb_stage_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

SOURCES  = $(shell grep -v '^+' $(FLIST))
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/wb_vectors.hex
// in: valid ctrl affected result_a result_c alu_flags neip neip_nt ncs hold_cycles
// exp: data1 final_eip final_cs count flags enables{repne_term,halt,ld_cs..ld_gpr1}
1 000041 7F 11111111 00000005 000008D5 00001000 00002000 0008 0 11111111 00001000 0008 00000005 000008D7 041
1 000044 09 22222222 00000000 FFFFFFBE 00001004 00002004 0008 2 22222222 00001004 0008 00000000 00000896 044
1 000040 30 33333333 00000010 00000400 00001008 00002008 0008 0 33333333 00001008 0008 00000010 00000C16 040
1 010020 00 44444444 00000001 00000000 0000100C 0000200C 0008 0 00000C16 0000100C 0008 00000001 00000C16 020
1 020000 00 FFFFFFFF 00000002 00000000 00001010 00002010 0008 0 FFFFFFFF 00001010 0008 00000002 00257FD5 040
1 020000 00 00000000 00000002 00000000 00001014 00002014 0008 0 00000000 00001014 0008 00000002 00210000 040
1 000201 00 0000A000 00000003 00000000 00001018 00002018 0008 0 0000A000 00001018 0008 00000003 00210000 001
1 0004C0 08 0000B000 00000004 00000040 0000101C 0000201C 0008 0 0000A000 0000101C 0008 00000004 00210040 040
1 000201 00 0000C000 00000005 00000000 00001020 00002020 0008 0 0000C000 00001020 0008 00000005 00210040 001
1 000CC0 08 0000C004 00000007 00000000 00001024 00002024 0008 1 0000C000 00001024 0008 00000007 00210000 040
1 000201 00 0000D000 00000006 00000000 00001028 00002028 0008 0 0000D000 00001028 0008 00000006 00210000 001
1 000CC0 08 0000D004 00000006 00000040 0000102C 0000202C 0008 0 0000D000 0000102C 0008 00000006 00210040 4C0
1 000201 00 0000E000 00000001 00000000 00001030 00002030 0008 0 0000E000 00001030 0008 00000001 00210040 001
1 000CC0 08 0000E004 00000000 00000000 00001034 00002034 0008 0 0000E000 00001034 0008 00000000 00210000 4C0
1 080000 00 55555555 00000000 00000000 00001038 00002038 0008 0 55555555 00001038 0008 00000000 00210000 200
0 0801FF 7F 66666666 00000000 FFFFFFFF 0000103C 0000203C 0008 0 66666666 0000103C 0008 00000000 00210000 000
1 040040 01 77777777 00000000 00000001 00001040 00002040 0008 0 77777777 00001040 0008 00000000 00210001 042
1 040042 01 88888888 00000000 00000000 00001044 00002044 0008 0 88888888 00001044 0008 00000000 00210000 040
1 1000C0 08 99999999 00000000 00000040 00001048 00002048 0008 3 99999999 00002048 0008 00000000 00210040 0C0
1 1000C0 08 99999999 00000000 00000000 0000104C 0000204C 0008 0 99999999 0000104C 0008 00000000 00210000 0C0
1 2000C0 01 99999999 00000000 00000001 00001050 00002050 0008 0 99999999 00002050 0008 00000000 00210001 0C0
1 2000C0 09 99999999 00000000 00000000 00001054 00002054 0008 0 99999999 00001054 0008 00000000 00210000 0C0
1 2000C0 08 99999999 00000000 00000040 00001058 00002058 0008 0 99999999 00002058 0008 00000000 00210040 0C0
1 003001 00 AAAAAAAA 00000000 00000000 0000105C 0000205C 0023 0 AAAAAAAA 0000105C 0023 00000000 00210040 001
1 00C180 00 BBBBBBBB 00000000 00000000 00001060 00002060 0008 0 BBBBBBBB 0000105C 0023 00000000 00210040 180
1 104080 00 BBBBBBBB 00000000 00000000 00001064 00002064 0010 0 BBBBBBBB 00002064 0010 00000000 00210040 080
0 000C80 00 CCCCCCCC 00000000 00000000 00001068 00002068 0008 3 0000E000 00001068 0008 00000000 00210040 000
1 000118 00 DDDDDDDD 00000009 00000000 0000106C 0000206C 0008 1 DDDDDDDD 0000106C 0008 00000009 00210040 118
